// File: bench/fetch_pc_patterns.txt
# op  operand_a  operand_b  test_name  expected_pc   (operands and pc in hex)
# FETCH/STALL take a cycle or fetch count in operand_a
RESET    0        0        reset_pc     FFFC0000
FETCH    3        0        seq_three    FFFC0048
STALL    4        0        stall_hold   FFFC0048
REDIR    00001000 0        redir_alone  00001000
COMMIT   00001048 00002000 train_taken  00001000
NTCOMMIT 00001030 00003000 train_nt     00001000
FETCH    2        0        seq_to_nt    00001030
FETCH    1        0        nt_no_hit    00001048
FETCH    1        0        hit_target   00002000
CALL     00004000 0        call_r1      00002000
CALL     00005000 0        call_r2      00002000
RET      0        0        ret_r2       00005000
RET      0        0        ret_r1       00004000
RET      0        0        ret_empty    FFFC0000
IRQREDIR 00007000 00008000 irq_wins     00007000
CALL     00009000 0        call_r3      00007000
RETREDIR 0000A000 0        ret_redir    0000A000
RET      0        0        ret_late     00009000
FETCH    2        0        seq_end      00009030

// File: fetch_pc_unit.f
src/fetch_pc_pkg.sv
src/btb_table.sv
src/return_stack.sv
src/next_pc_ctrl.sv
src/fetch_pc_unit.sv
bench/fetch_pc_checker.sv
bench/fetch_pc_unit_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := fetch_pc_unit_tb
FILELIST  := fetch_pc_unit.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "*** PASSED ***"

clean:
	rm -rf $(OBJDIR)

// File: bench/fetch_pc_unit_tb.sv
/*
  Testbench for the fetch program-counter unit.
  Reads test steps from the pattern file and drives the DUT.
  The checker module compares the results and counts them.
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_unit_tb
  import fetch_pc_pkg::*;
;

  logic        clk;
  logic        rst;
  logic        pc_ready;
  pc_addr_t    pc;
  logic        pc_valid;
  logic        btb_taken;
  logic        irq;
  pc_addr_t    irq_addr;
  redirect_t   redirect;
  logic        call;
  pc_addr_t    ret_pc;
  logic        ret;
  commit_upd_t commit;

  // step bookkeeping shared with the checker
  logic              step_done;
  logic [8*16-1:0]   step_name;
  pc_addr_t          step_exp;
  int                pass_cnt;
  int                fail_cnt;

  int                seed = 34;  // pc_ready gaps
  int                bench_errs;

  fetch_pc_unit #(.BTB_DEPTH(1024), .RAS_DEPTH(32)) UUT (
    .clk(clk), .rst(rst), .pc_ready(pc_ready), .pc(pc), .pc_valid(pc_valid),
    .btb_taken(btb_taken), .irq(irq), .irq_addr(irq_addr), .redirect(redirect),
    .call(call), .ret_pc(ret_pc), .ret(ret), .commit(commit)
  );

  fetch_pc_checker #(.BTB_DEPTH(1024), .RAS_DEPTH(32)) u_checker (
    .clk(clk), .rst(rst), .pc_ready(pc_ready), .pc(pc), .pc_valid(pc_valid),
    .btb_taken(btb_taken), .irq(irq), .irq_addr(irq_addr), .redirect(redirect),
    .call(call), .ret_pc(ret_pc), .ret(ret), .commit(commit),
    .step_done(step_done), .step_name(step_name), .step_exp(step_exp),
    .pass_cnt(pass_cnt), .fail_cnt(fail_cnt)
  );

  // ==================================================
  // 20 ns clock
  // ==================================================
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // all inputs back to rest with pc_ready low
  task automatic drive_idle();
    pc_ready <= 1'b0;
    irq      <= 1'b0;
    redirect <= '0;
    call     <= 1'b0;
    ret      <= 1'b0;
    commit   <= '0;
  endtask

  // one-cycle change of flow or stack event followed by idle and the step flag
  task automatic pulse_and_close(input logic [8*16-1:0] name, input pc_addr_t exp);
    @(posedge clk);
    drive_idle();
    step_name <= name;
    step_exp  <= exp;
    step_done <= 1'b1;
    @(posedge clk);
    step_done <= 1'b0;
  endtask

  // n accepted fetches with random ready gaps
  task automatic fetch_n(input int n, input logic [8*16-1:0] name);
    int   acc;
    int   cyc;
    logic hs;
    acc = 0;
    cyc = 0;
    pc_ready <= 1'b1;
    while (acc < n && cyc < 200) begin
      @(negedge clk);
      hs = pc_valid && pc_ready;          // handshake completes at the coming edge
      @(posedge clk);
      cyc++;
      if (hs) acc++;
      if (acc < n) pc_ready <= (($random(seed) & 3) != 0);
      else pc_ready <= 1'b0;
    end
    if (acc < n) begin
      $display("timeout in %0s: only %0d of %0d fetches accepted", name, acc, n);
      bench_errs++;
      pc_ready <= 1'b0;
    end
  endtask

  task automatic commit_branch(input logic tk, input pc_addr_t a, input pc_addr_t t);
    @(posedge clk);
    commit <= '{valid: 1'b1, taken: tk, pc: a, tgt: t};
    @(posedge clk);
    commit <= '0;                         // edge 1 captured it
  endtask

  // ==================================================
  // pattern reader and stimulus
  // ==================================================
  initial begin
    int              fd;
    int              n;
    int              rcyc;
    string           line;
    logic [8*12-1:0] op;
    pc_addr_t        a;
    pc_addr_t        b;
    logic [8*16-1:0] name;
    pc_addr_t        exp;

    rst        = 1'b1;
    irq_addr   = '0;
    ret_pc     = '0;
    pc_ready   = 1'b0;
    irq        = 1'b0;
    redirect   = '0;
    call       = 1'b0;
    ret        = 1'b0;
    commit     = '0;
    step_done  = 1'b0;
    step_name  = '0;
    step_exp   = '0;
    bench_errs = 0;

    fd = $fopen("bench/fetch_pc_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file");
      $display("*** FAILED ***");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        n = $sscanf(line, "%s %h %h %s %h", op, a, b, name, exp);
        if (n == 5 && line.getc(0) != "#") begin
          case (op)
            "RESET": begin
              rst <= 1'b1;
              drive_idle();
              rcyc = 0;
              while (rcyc < 2) begin  // two reset cycles
                @(posedge clk);
                rcyc++;
              end
              rst <= 1'b0;
              step_name <= name;
              step_exp  <= exp;
              step_done <= 1'b1;
              @(posedge clk);
              step_done <= 1'b0;
            end
            "FETCH": begin
              fetch_n(int'(a), name);
              step_name <= name;
              step_exp  <= exp;
              step_done <= 1'b1;
              @(posedge clk);
              step_done <= 1'b0;
            end
            "STALL": begin
              repeat (int'(a)) @(posedge clk);
              pulse_and_close(name, exp);
            end
            "COMMIT": begin
              commit_branch(1'b1, a, b);
              pulse_and_close(name, exp);
            end
            "NTCOMMIT": begin
              commit_branch(1'b0, a, b);
              pulse_and_close(name, exp);
            end
            "CALL": begin
              @(posedge clk);
              call   <= 1'b1;
              ret_pc <= a;
              pulse_and_close(name, exp);
            end
            "RET": begin
              @(posedge clk);
              ret <= 1'b1;
              pulse_and_close(name, exp);
            end
            "IRQREDIR": begin
              @(posedge clk);
              irq      <= 1'b1;
              irq_addr <= a;
              redirect <= '{valid: 1'b1, target: b};
              pulse_and_close(name, exp);
            end
            "REDIR": begin
              @(posedge clk);
              redirect <= '{valid: 1'b1, target: a};
              pulse_and_close(name, exp);
            end
            "RETREDIR": begin
              @(posedge clk);
              ret      <= 1'b1;
              redirect <= '{valid: 1'b1, target: a};
              pulse_and_close(name, exp);
            end
            default: begin
              $display("unknown operation in pattern file: %0s", op);
              bench_errs++;
            end
          endcase
        end
      end
      $fclose(fd);

      repeat (2) @(posedge clk);
      $display("tests: %0d passed, %0d failed, %0d bench errors",
               pass_cnt, fail_cnt, bench_errs);
      if (fail_cnt == 0 && bench_errs == 0 && pass_cnt > 0) begin
        $display("*** PASSED ***");
      end else begin
        $display("*** FAILED ***");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: bench/fetch_pc_checker.sv
/*
  Checker for the fetch program-counter unit.
  Keeps its own model of counter, branch table and return stack,
  compares every cycle and reports one line per finished test.
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_checker
  import fetch_pc_pkg::*;
#(
  parameter int BTB_DEPTH = 1024,
  parameter int RAS_DEPTH = 32
) (
  input  wire             clk,
  input  wire             rst,
  input  wire             pc_ready,
  input  pc_addr_t        pc,
  input  wire             pc_valid,
  input  wire             btb_taken,
  input  wire             irq,
  input  pc_addr_t        irq_addr,
  input  redirect_t       redirect,
  input  wire             call,
  input  pc_addr_t        ret_pc,
  input  wire             ret,
  input  commit_upd_t     commit,
  input  wire             step_done,   // a test step ends this cycle
  input  wire [8*16-1:0]  step_name,
  input  pc_addr_t        step_exp,    // counter value from the pattern file
  output int              pass_cnt,
  output int              fail_cnt
);

  // model state, valid after the first reset edge
  logic     m_init = 1'b0;
  pc_addr_t m_pc;
  logic     m_valid;
  logic     m_tk  [BTB_DEPTH];
  pc_addr_t m_tag [BTB_DEPTH];
  pc_addr_t m_tgt [BTB_DEPTH];
  logic     pend_v;                 // staged taken commit
  pc_addr_t pend_pc;
  pc_addr_t pend_tgt;
  pc_addr_t m_ras [RAS_DEPTH];
  int       m_sp;
  int       step_errs = 0;
  string    first_err;

  initial begin
    pass_cnt = 0;
    fail_cnt = 0;
  end

  function automatic int slot_of(input pc_addr_t a);
    return int'((a >> 1) % BTB_DEPTH);  // bits above bit 0
  endfunction

  // ==================================================
  // sampled mid-cycle, inputs and outputs are settled
  // ==================================================
  always @(negedge clk) begin
    logic     m_hit;
    logic     acc;
    pc_addr_t nxt;
    int       s;

    if (m_init) begin
      s     = slot_of(m_pc);
      m_hit = m_tk[s] && (m_tag[s] == m_pc);
      if (pc !== m_pc || pc_valid !== m_valid || btb_taken !== m_hit) begin
        if (step_errs == 0)
          $sformat(first_err, "pc %h/%h valid %b/%b taken %b/%b", m_pc, pc,
                   m_valid, pc_valid, m_hit, btb_taken);
        step_errs++;
      end
    end else begin
      m_hit = 1'b0;
    end

    if (step_done) begin
      if (pc !== step_exp) begin
        $display("FAIL %0s expected %h actual %h", step_name, step_exp, pc);
        fail_cnt++;
      end else if (step_errs != 0) begin
        $display("FAIL %0s expected/actual %0s", step_name, first_err);
        fail_cnt++;
      end else begin
        $display("PASS %0s pc %h", step_name, pc);
        pass_cnt++;
      end
      step_errs = 0;
    end

    // state after the coming rising edge
    if (rst) begin
      m_init  = 1'b1;
      m_pc    = RESET_PC;
      m_valid = 1'b0;
      pend_v  = 1'b0;
      m_sp    = 0;
      for (int i = 0; i < BTB_DEPTH; i++) m_tk[i] = 1'b0;
      for (int i = 0; i < RAS_DEPTH; i++) m_ras[i] = RESET_PC;
    end else if (m_init) begin
      acc = m_valid && pc_ready;
      if (irq)                   nxt = irq_addr;
      else if (redirect.valid)   nxt = redirect.target;
      else if (ret)              nxt = m_ras[m_sp];
      else if (acc && m_hit)     nxt = m_tgt[slot_of(m_pc)];
      else if (acc)              nxt = m_pc + FETCH_STEP;
      else                       nxt = m_pc;
      // return stack, pop is cancelled by irq or redirect
      if (call && !(ret && !irq && !redirect.valid)) begin
        m_sp = (m_sp + RAS_DEPTH - 1) % RAS_DEPTH;
        m_ras[m_sp] = ret_pc;
      end else if (!call && ret && !irq && !redirect.valid) begin
        m_sp = (m_sp + 1) % RAS_DEPTH;
      end
      // table write from last cycle's staged commit
      if (pend_v) begin
        s        = slot_of(pend_pc);
        m_tk[s]  = 1'b1;
        m_tag[s] = pend_pc;
        m_tgt[s] = pend_tgt;
      end
      pend_v   = commit.valid && commit.taken;
      pend_pc  = commit.pc;
      pend_tgt = commit.tgt;
      m_pc     = nxt;
      m_valid  = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: src/fetch_pc_unit.sv
/*
  Fetch program-counter unit top level.
  Sets table and stack sizes and connects control to both datapath blocks.
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_unit
  import fetch_pc_pkg::*;
#(
  parameter int BTB_DEPTH = 1024,  // table entries
  parameter int RAS_DEPTH = 32     // return stack slots
) (
  input  wire         clk,
  input  wire         rst,
  input  wire         pc_ready,
  output pc_addr_t    pc,
  output logic        pc_valid,
  output logic        btb_taken,
  input  wire         irq,
  input  pc_addr_t    irq_addr,
  input  redirect_t   redirect,
  input  wire         call,
  input  pc_addr_t    ret_pc,     // address after the call
  input  wire         ret,
  input  commit_upd_t commit
);

  pc_addr_t lookup_pc;
  logic     hit;
  pc_addr_t hit_target;
  pc_addr_t ras_top;
  logic     pop;  // gated ret

  // ==================================================
  // control
  // ==================================================
  next_pc_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .pc_ready   (pc_ready),
    .pc         (pc),
    .pc_valid   (pc_valid),
    .btb_taken  (btb_taken),
    .irq        (irq),
    .irq_addr   (irq_addr),
    .redirect   (redirect),
    .ret        (ret),
    .lookup_pc  (lookup_pc),
    .hit        (hit),
    .hit_target (hit_target),
    .ras_top    (ras_top),
    .pop        (pop)
  );

  // ==================================================
  // datapath
  // ==================================================
  btb_table #(.BTB_DEPTH(BTB_DEPTH)) u_btb (
    .clk        (clk),
    .rst        (rst),
    .commit     (commit),
    .lookup_pc  (lookup_pc),
    .hit        (hit),
    .hit_target (hit_target)
  );

  return_stack #(.RAS_DEPTH(RAS_DEPTH)) u_ras (
    .clk       (clk),
    .rst       (rst),
    .push      (call),     // every call pushes
    .push_addr (ret_pc),
    .pop       (pop),
    .top       (ras_top)
  );

endmodule

`default_nettype wire

// File: src/next_pc_ctrl.sv
/*
  Program counter register and next-counter selection.
  Priority: irq, redirect, return, taken table hit, sequential step.
  The table hit and sequential step only advance on an accepted fetch.
*/
`timescale 1ns/1ps
`default_nettype none

module next_pc_ctrl
  import fetch_pc_pkg::*;
(
  input  wire       clk,
  input  wire       rst,
  // fetch handshake
  input  wire       pc_ready,    // fetch stage can take pc
  output pc_addr_t  pc,          // current fetch address
  output logic      pc_valid,
  output logic      btb_taken,   // current pc predicted taken
  // change of flow sources
  input  wire       irq,
  input  pc_addr_t  irq_addr,
  input  redirect_t redirect,    // decode correction
  input  wire       ret,         // return seen by decode
  // branch target buffer
  output pc_addr_t  lookup_pc,
  input  wire       hit,
  input  pc_addr_t  hit_target,
  // return stack
  input  pc_addr_t  ras_top,
  output logic      pop
);

  logic     fetch_acc;  // fetch handshake completes this cycle
  pc_addr_t next_pc;

  assign fetch_acc = pc_valid & pc_ready;
  assign lookup_pc = pc;        // table probed with the current counter
  assign btb_taken = hit;

  // a higher priority change of flow cancels the return, stack keeps its top
  assign pop = ret & ~irq & ~redirect.valid;

  // ==================================================
  // next counter
  // ==================================================
  always_comb begin
    if (irq) begin
      next_pc = irq_addr;              // highest priority, ignores pc_ready
    end else if (redirect.valid) begin
      next_pc = redirect.target;
    end else if (ret) begin
      next_pc = ras_top;
    end else if (fetch_acc && hit) begin
      next_pc = hit_target;            // predicted taken branch
    end else if (fetch_acc) begin
      next_pc = pc + FETCH_STEP;       // next fetch group
    end else begin
      next_pc = pc;                    // stalled, hold
    end
  end

  // ==================================================
  // registers
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      pc       <= RESET_PC;
      pc_valid <= 1'b0;
    end else begin
      pc       <= next_pc;
      pc_valid <= 1'b1;  // single thread, always something to fetch
    end
  end

endmodule

`default_nettype wire

// File: src/return_stack.sv
/*
  Circular return-address stack.
  A call pushes the return address, a return pops it; both at once is a no-op.
*/
`timescale 1ns/1ps
`default_nettype none

module return_stack
  import fetch_pc_pkg::*;
#(
  parameter int RAS_DEPTH = 32  // slots, power of two
) (
  input  wire      clk,
  input  wire      rst,
  input  wire      push,       // call seen
  input  pc_addr_t push_addr,  // return address to save
  input  wire      pop,        // return taken
  output pc_addr_t top         // current top of stack
);

  localparam int PTR_W = $clog2(RAS_DEPTH);

  pc_addr_t         slots [RAS_DEPTH];
  logic [PTR_W-1:0] sp;      // points at the top slot
  logic [PTR_W-1:0] sp_dec;  // slot a push lands in

  assign sp_dec = sp - 1'b1;  // wraps around, stack is circular
  assign top    = slots[sp];

  // ==================================================
  // pointer
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      sp <= '0;
    end else begin
      case ({pop, push})
        2'b01:   sp <= sp_dec;     // push grows downward
        2'b10:   sp <= sp + 1'b1;  // pop
        default: sp <= sp;         // idle, or call and ret cancel out
      endcase
    end
  end

  // ==================================================
  // storage
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < RAS_DEPTH; i++) begin
        slots[i] <= RESET_PC;  // underflow returns to boot vector
      end
    end else if (push && !pop) begin
      slots[sp_dec] <= push_addr;
    end
  end

endmodule

`default_nettype wire

// File: src/btb_table.sv
/*
  Direct-mapped branch target buffer.
  Commit updates are staged one cycle, then written; lookup is combinational.
*/
`timescale 1ns/1ps
`default_nettype none

module btb_table
  import fetch_pc_pkg::*;
#(
  parameter int BTB_DEPTH = 1024  // entries, power of two
) (
  input  wire         clk,
  input  wire         rst,
  input  commit_upd_t commit,      // branch outcome from commit
  input  pc_addr_t    lookup_pc,   // current fetch address
  output logic        hit,         // taken entry matches lookup_pc
  output pc_addr_t    hit_target   // predicted target on hit
);

  localparam int IDX_W = $clog2(BTB_DEPTH);

  btb_entry_t entries [BTB_DEPTH];  // the table itself

  // ==================================================
  // commit staging, edge 1
  // ==================================================
  logic             wr_en;     // write pending
  logic [IDX_W-1:0] wr_idx;    // slot to write
  btb_entry_t       wr_entry;  // staged payload

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= commit.valid & commit.taken;  // not-taken outcomes are dropped
    end
    wr_idx         <= commit.pc[IDX_W:1];    // bit 0 skipped, as in lookup
    wr_entry.taken <= commit.taken;
    wr_entry.pc    <= commit.pc;
    wr_entry.tgt   <= commit.tgt;
  end

  // ==================================================
  // table write, edge 2
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < BTB_DEPTH; i++) begin
        entries[i] <= '0;  // all slots not-taken
      end
    end else if (wr_en) begin
      entries[wr_idx] <= wr_entry;
    end
  end

  // ==================================================
  // lookup
  // ==================================================
  logic [IDX_W-1:0] rd_idx;
  btb_entry_t       rd_entry;

  assign rd_idx   = lookup_pc[IDX_W:1];
  assign rd_entry = entries[rd_idx];

  // full tag compare, no aliasing between addresses sharing a slot
  assign hit        = rd_entry.taken && (rd_entry.pc == lookup_pc);
  assign hit_target = rd_entry.tgt;

endmodule

`default_nettype wire

// File: src/fetch_pc_pkg.sv
/*
  Shared types and constants for the fetch program-counter unit.
  Imported by every RTL block of the fetch front end.
*/
`default_nettype none

package fetch_pc_pkg;

  // ==================================================
  // address type and fixed constants
  // ==================================================
  typedef logic [31:0] pc_addr_t;                 // fetch byte address

  localparam pc_addr_t RESET_PC   = 32'hFFFC0000;  // boot vector, also empty stack slot
  localparam pc_addr_t FETCH_STEP = 32'd24;        // 4 instructions x 6 bytes

  // ==================================================
  // bundles
  // ==================================================

  // one branch target buffer slot
  typedef struct packed {
    logic     taken;  // predict taken
    pc_addr_t pc;     // full branch address, used as tag
    pc_addr_t tgt;    // predicted target
  } btb_entry_t;

  // decode stage correction
  typedef struct packed {
    logic     valid;
    pc_addr_t target;
  } redirect_t;

  // branch outcome from commit, trains the table
  typedef struct packed {
    logic     valid;
    logic     taken;
    pc_addr_t pc;   // branch address
    pc_addr_t tgt;  // resolved target
  } commit_upd_t;

endpackage

`default_nettype wire
